// File: hw/axi_lite_pkg.sv
package axi_lite_pkg;

  localparam int AXI_ADDR_WIDTH = 16;  // Byte address width of the slave
  localparam int AXI_DATA_WIDTH = 32;  // Read data width, one sample per beat

  // Bits needed to hold value, used to find the byte-lane offset
  function automatic int clogb2(input int value);
    int bits;
    int v;
    bits = 0;
    v = value;
    while (v > 0) begin
      bits++;
      v = v >> 1;
    end
    return bits;
  endfunction

  // Low byte-address bits that select a lane inside one data word
  localparam int ADDR_LSB = clogb2(AXI_DATA_WIDTH / 8 - 1);

endpackage

// File: hw/mem_pkg.sv
package mem_pkg;

  // One RAM word holds exactly one sample
  localparam int SAMPLE_WIDTH = 32;

  // Word address width of the sample buffer, 1024 words deep
  localparam int RAM_ADDR_WIDTH = 10;

endpackage

// File: hw/bram_if.sv
`timescale 1ns/1ps

interface bram_if #(
  parameter int ADDR_WIDTH = mem_pkg::RAM_ADDR_WIDTH,
  parameter int DATA_WIDTH = mem_pkg::SAMPLE_WIDTH
);

  logic                  wr_en;    // Write strobe, lands on this edge
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_en;    // Read request, data one cycle later
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;  // Holds while rd_en is low

  modport writer (
    output wr_en,
    output wr_addr,
    output wr_data
  );

  modport reader (
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport memory (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: hw/sample_recorder.sv
`timescale 1ns/1ps

module sample_recorder #(
  parameter int BLOCK_LENGTH = 1024,
  parameter int ADDR_WIDTH   = mem_pkg::RAM_ADDR_WIDTH
) (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic                          sample_valid,
  input  logic [mem_pkg::SAMPLE_WIDTH-1:0] sample_data,
  output logic                          done,
  bram_if.writer                        ram
);

  localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(BLOCK_LENGTH - 1);

  logic                  busy;
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic                  take;

  // Start wins over a sample strobe arriving in the same cycle
  assign take = busy && sample_valid && !start;

  assign ram.wr_en   = take;
  assign ram.wr_addr = wr_ptr;
  assign ram.wr_data = sample_data;  // Written on the same edge as the strobe

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      wr_ptr <= '0;
      done   <= 1'b0;
    end else if (start) begin
      busy   <= 1'b1;  // Arm a new block
      wr_ptr <= '0;
      done   <= 1'b0;
    end else if (take) begin
      if (wr_ptr == LAST_ADDR) begin
        busy <= 1'b0;  // Block full
        done <= 1'b1;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

endmodule

// File: hw/sample_bram.sv
`timescale 1ns/1ps

module sample_bram #(
  parameter int ADDR_WIDTH = mem_pkg::RAM_ADDR_WIDTH,
  parameter int DATA_WIDTH = mem_pkg::SAMPLE_WIDTH
) (
  input  logic    aclk,
  bram_if.memory  ram
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge aclk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Registered read port, sees the old word on a same-address write
  always_ff @(posedge aclk) begin
    if (ram.rd_en) begin
      ram.rd_data <= mem[ram.rd_addr];
    end
  end

endmodule

// File: hw/input_buffer.sv
`timescale 1ns/1ps

module input_buffer #(
  parameter int DATA_WIDTH = axi_lite_pkg::AXI_ADDR_WIDTH
) (
  input  logic                  aclk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [DATA_WIDTH-1:0] skid_data;  // Second entry, behind the output register
  logic                  skid_valid;
  logic                  push;
  logic                  pop;
  logic                  load_out_in;
  logic                  load_out_skid;
  logic                  load_skid;

  assign in_ready = !skid_valid;  // Accept while one entry is free
  assign push     = in_valid && in_ready;
  assign pop      = out_valid && out_ready;

  // Where an accepted word goes this cycle
  assign load_out_skid = pop && skid_valid;
  assign load_out_in   = push && (pop || !out_valid);
  assign load_skid     = push && out_valid && !pop;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (load_out_skid) begin
        skid_valid <= 1'b0;  // Out stays valid with the older entry
      end else if (load_out_in) begin
        out_valid <= 1'b1;
      end else if (pop) begin
        out_valid <= 1'b0;
      end
      if (load_skid) begin
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load_out_skid) begin
      out_data <= skid_data;
    end else if (load_out_in) begin
      out_data <= in_data;
    end
    if (load_skid) begin
      skid_data <= in_data;
    end
  end

endmodule

// File: hw/output_buffer.sv
`timescale 1ns/1ps

module output_buffer (
  input  logic aclk,
  input  logic rst_n,
  input  logic in_valid,
  output logic in_ready,
  output logic out_valid,
  input  logic out_ready,
  output logic out_en
);

  logic slot_free;

  // Response slot is empty or being drained this cycle
  assign slot_free = !out_valid || out_ready;

  // One RAM read per buffered address, pops the address at the same edge
  assign out_en   = in_valid && slot_free;
  assign in_ready = out_en;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (out_en) begin
      out_valid <= 1'b1;  // RAM data arrives with this edge
    end else if (out_ready) begin
      out_valid <= 1'b0;  // Response taken, nothing behind it
    end
  end

endmodule

// File: hw/axi_bram_reader.sv
`timescale 1ns/1ps

module axi_bram_reader #(
  parameter int AXI_ADDR_WIDTH = axi_lite_pkg::AXI_ADDR_WIDTH,
  parameter int RAM_ADDR_WIDTH = mem_pkg::RAM_ADDR_WIDTH
) (
  input  logic                                    aclk,
  input  logic                                    rst_n,
  input  logic [AXI_ADDR_WIDTH-1:0]               s_axi_araddr,
  input  logic                                    s_axi_arvalid,
  output logic                                    s_axi_arready,
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output logic                                    s_axi_rvalid,
  input  logic                                    s_axi_rready,
  bram_if.reader                                  ram
);

  import axi_lite_pkg::*;

  logic [AXI_ADDR_WIDTH-1:0] buf_addr;  // Oldest pending byte address
  logic                      buf_valid;
  logic                      buf_ready;
  logic                      rd_en;

  input_buffer #(
    .DATA_WIDTH(AXI_ADDR_WIDTH)
  ) addr_buf (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_data   (s_axi_araddr),
    .in_valid  (s_axi_arvalid),
    .in_ready  (s_axi_arready),
    .out_data  (buf_addr),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  output_buffer resp_buf (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (buf_valid),
    .in_ready  (buf_ready),
    .out_valid (s_axi_rvalid),
    .out_ready (s_axi_rready),
    .out_en    (rd_en)
  );

  // Word address drops the byte lane, upper bits alias
  assign ram.rd_addr = buf_addr[ADDR_LSB+RAM_ADDR_WIDTH-1:ADDR_LSB];
  assign ram.rd_en   = rd_en;
  assign s_axi_rdata = ram.rd_data;  // RAM output register holds the response

endmodule

// File: hw/bram_reader_system.sv
`timescale 1ns/1ps

module bram_reader_system #(
  parameter int AXI_ADDR_WIDTH = axi_lite_pkg::AXI_ADDR_WIDTH,
  parameter int RAM_ADDR_WIDTH = mem_pkg::RAM_ADDR_WIDTH,
  parameter int BLOCK_LENGTH   = 1024
) (
  input  logic                                    aclk,
  input  logic                                    rst_n,
  // Recorder side
  input  logic                                    start,
  input  logic                                    sample_valid,
  input  logic [mem_pkg::SAMPLE_WIDTH-1:0]        sample_data,
  output logic                                    done,
  // AXI4-Lite read channels
  input  logic [AXI_ADDR_WIDTH-1:0]               s_axi_araddr,
  input  logic                                    s_axi_arvalid,
  output logic                                    s_axi_arready,
  output logic [axi_lite_pkg::AXI_DATA_WIDTH-1:0] s_axi_rdata,
  output logic                                    s_axi_rvalid,
  input  logic                                    s_axi_rready
);

  import mem_pkg::*;

  bram_if #(
    .ADDR_WIDTH (RAM_ADDR_WIDTH),
    .DATA_WIDTH (SAMPLE_WIDTH)
  ) ram_bus ();

  sample_recorder #(
    .BLOCK_LENGTH (BLOCK_LENGTH),
    .ADDR_WIDTH   (RAM_ADDR_WIDTH)
  ) recorder (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .start        (start),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .done         (done),
    .ram          (ram_bus.writer)
  );

  sample_bram #(
    .ADDR_WIDTH (RAM_ADDR_WIDTH),
    .DATA_WIDTH (SAMPLE_WIDTH)
  ) ram (
    .aclk (aclk),
    .ram  (ram_bus.memory)
  );

  axi_bram_reader #(
    .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH),
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) reader (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .ram           (ram_bus.reader)
  );

endmodule

// File: testbench/tb_bram_reader_system.sv
`timescale 1ns/1ps

module tb_bram_reader_system;

  localparam int RAM_AW    = 4;
  localparam int BLOCK_LEN = 12;
  localparam int CLK_NS    = 10;
  // Cycle budget of each test, reset first, rerecording last
  localparam int RUN_CYCLES  = 12 + 90 + 4 + 15 + 24 + 55;
  localparam int WATCHDOG_NS = 2 * CLK_NS * RUN_CYCLES;

  logic        aclk = 1'b0;
  logic        rst_n;
  logic        start;
  logic        sample_valid;
  logic [31:0] sample_data;
  logic        done;
  logic [15:0] s_axi_araddr;
  logic        s_axi_arvalid;
  logic        s_axi_arready;
  logic [31:0] s_axi_rdata;
  logic        s_axi_rvalid;
  logic        s_axi_rready;

  logic [31:0] model_mem [16];      // Expected RAM contents
  logic        model_written [16];
  logic        model_busy;
  logic        model_done;
  int          model_ptr;
  logic [31:0] rng_state = 32'had0f;

  bram_reader_system #(
    .RAM_ADDR_WIDTH (RAM_AW),
    .BLOCK_LENGTH   (BLOCK_LEN)
  ) dut0 (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .start         (start),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .done          (done),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready)
  );

  always #(CLK_NS / 2) aclk = ~aclk;

  task automatic check_equal(string what, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic abort_run(string why);
    $display("Simulation stopped: %s", why);
    $display("TEST FAILED");
    $fatal(1, "Run aborted");
  endtask

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Four bytes per word, word index wraps at the RAM depth
  function automatic int word_of(logic [15:0] addr);
    return (int'(addr) / 4) % (2 ** RAM_AW);
  endfunction

  task automatic pulse_start();
    start = 1'b1;
    @(negedge aclk);
    start      = 1'b0;
    model_busy = 1'b1;
    model_done = 1'b0;
    model_ptr  = 0;
  endtask

  task automatic send_sample(logic [31:0] data);
    sample_valid = 1'b1;
    sample_data  = data;
    @(negedge aclk);
    sample_valid = 1'b0;
    if (model_busy) begin  // Strobes outside a block are dropped
      model_mem[model_ptr]     = data;
      model_written[model_ptr] = 1'b1;
      model_ptr++;
      model_busy = (model_ptr < BLOCK_LEN);
      model_done = !model_busy;
    end
  endtask

  // arready only moves on a rising edge, so its value here holds for the next edge
  task automatic send_address(logic [15:0] addr);
    int waited;
    waited        = 0;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    while (!s_axi_arready) begin
      @(negedge aclk);
      waited++;
      if (waited > 20) abort_run("arready stayed low for 20 cycles");
    end
    @(negedge aclk);
    s_axi_arvalid = 1'b0;
  endtask

  task automatic receive_response(output logic [31:0] data);
    int waited;
    waited       = 0;
    s_axi_rready = 1'b1;
    while (!s_axi_rvalid) begin
      @(negedge aclk);
      waited++;
      if (waited > 20) abort_run("no read response arrived within 20 cycles");
    end
    data = s_axi_rdata;
    @(negedge aclk);
    s_axi_rready = 1'b0;
  endtask

  task automatic read_check(logic [15:0] addr);
    logic [31:0] data;
    send_address(addr);
    receive_response(data);
    check_equal($sformatf("rdata at %h", addr), data, model_mem[word_of(addr)]);
  endtask

  task automatic check_idle(string when);
    check_equal({"rvalid ", when}, s_axi_rvalid, 0);
    check_equal({"done ", when}, done, 0);
    check_equal({"arready ", when}, s_axi_arready, 1);
  endtask

  task automatic test_record_and_read();
    send_sample(32'hdead_beef);  // Not armed yet
    check_equal("done before start", done, 0);
    pulse_start();
    for (int i = 0; i < BLOCK_LEN; i++) begin
      repeat (i % 3) @(negedge aclk);  // Idle gaps between strobes
      rng_state = lcg_next(rng_state);
      send_sample(rng_state);
      check_equal($sformatf("done after sample %0d", i), done, model_done);
    end
    check_equal("done after full block", done, 1);
    send_sample(32'hbad0_cafe);  // Block full, must not land
    check_equal("done after stray strobe", done, 1);
    for (int w = 0; w < BLOCK_LEN; w++) begin
      read_check(16'(w * 4));
    end
  endtask

  task automatic test_fixed_latency();
    s_axi_rready  = 1'b1;
    s_axi_araddr  = 16'h000c;
    s_axi_arvalid = 1'b1;
    check_equal("arready before single read", s_axi_arready, 1);
    @(negedge aclk);  // Handshake edge behind us
    s_axi_arvalid = 1'b0;
    check_equal("rvalid while RAM is read", s_axi_rvalid, 0);
    @(negedge aclk);
    check_equal("rvalid two cycles after arvalid", s_axi_rvalid, 1);
    check_equal("rdata of word 3", s_axi_rdata, model_mem[3]);
    @(negedge aclk);
    check_equal("rvalid after transfer", s_axi_rvalid, 0);
    s_axi_rready = 1'b0;
  endtask

  task automatic test_back_pressure();
    logic [15:0] addrs [3];
    logic [31:0] held;
    logic [31:0] data;
    addrs        = '{16'h0014, 16'h0020, 16'h0004};
    s_axi_rready = 1'b0;
    send_address(addrs[0]);
    send_address(addrs[1]);
    check_equal("arready with one address pending", s_axi_arready, 1);
    send_address(addrs[2]);
    check_equal("arready with two addresses pending", s_axi_arready, 0);
    check_equal("rvalid under back-pressure", s_axi_rvalid, 1);
    held = s_axi_rdata;
    repeat (4) begin
      @(negedge aclk);
      check_equal("rvalid held", s_axi_rvalid, 1);
      check_equal("rdata held", s_axi_rdata, held);
      check_equal("arready while buffer full", s_axi_arready, 0);
    end
    for (int i = 0; i < 3; i++) begin
      receive_response(data);
      check_equal($sformatf("response %0d in order", i), data,
                  model_mem[word_of(addrs[i])]);
    end
  endtask

  task automatic test_address_mapping();
    logic [15:0] addrs [6];
    addrs = '{16'h0005, 16'h002b, 16'h0046, 16'h4022, 16'h0c9a, 16'hffee};
    foreach (addrs[i]) begin
      if (!model_written[word_of(addrs[i])]) abort_run("alias list names an unwritten word");
      read_check(addrs[i]);
    end
  endtask

  task automatic test_rerecording();
    pulse_start();
    check_equal("done after second start", done, 0);
    for (int i = 0; i < 5; i++) begin
      rng_state = lcg_next(rng_state);
      send_sample(rng_state);
      check_equal("done while rerecording", done, 0);
    end
    for (int w = 0; w < BLOCK_LEN; w++) begin
      read_check(16'(w * 4));  // New words 0 to 4, old ones above
    end
    check_equal("done after partial block", done, 0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    rst_n         = 1'b0;
    start         = 1'b0;
    sample_valid  = 1'b0;
    sample_data   = '0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    model_busy    = 1'b0;
    model_done    = 1'b0;
    model_ptr     = 0;
    foreach (model_written[i]) model_written[i] = 1'b0;
    repeat (3) @(negedge aclk);
    check_idle("during reset");
    repeat (7) @(negedge aclk);  // Ten rising edges with reset low
    rst_n = 1'b1;
    @(negedge aclk);
    check_idle("after reset");
    test_record_and_read();
    test_fixed_latency();
    test_back_pressure();
    test_address_mapping();
    test_rerecording();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: sim.f
hw/axi_lite_pkg.sv
hw/mem_pkg.sv
hw/bram_if.sv
hw/sample_recorder.sv
hw/sample_bram.sv
hw/input_buffer.sv
hw/output_buffer.sv
hw/axi_bram_reader.sv
hw/bram_reader_system.sv
testbench/tb_bram_reader_system.sv

// File: Bender.yml
package:
  name: bram_reader_system

sources:
  - hw/axi_lite_pkg.sv
  - hw/mem_pkg.sv
  - hw/bram_if.sv
  - hw/sample_recorder.sv
  - hw/sample_bram.sv
  - hw/input_buffer.sv
  - hw/output_buffer.sv
  - hw/axi_bram_reader.sv
  - hw/bram_reader_system.sv
  - target: test
    files:
      - testbench/tb_bram_reader_system.sv
